// ==== common/awp_defines.svh ====
`ifndef AWP_DEFINES_SVH
`define AWP_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath geometry
//////////////////////////////////////////////////

// Quads in the cascade chain
`define AWP_NUM_QUADS       4
// Pixel and dot product width
`define AWP_PIXEL_W         16
`define AWP_WEIGHT_W        8

// Ingress word is meta over payload
`define AWP_PYLD_W          64
`define AWP_META_W          2

//////////////////////////////////////////////////
// Result buffering and flow control
//////////////////////////////////////////////////

`define AWP_FIFO_DEPTH      16
// Wide enough to hold a full FIFO worth of credits
`define AWP_CREDIT_W        5
`define AWP_WMARK_DEFAULT   16

// Meta kinds, codes 0 and 3 are dropped
`define AWP_META_CFG        2'd1
`define AWP_META_PIXEL      2'd2

`endif

// ==== common/awp_pkg.sv ====
`default_nettype none

`include "awp_defines.svh"

package awp_pkg;

    // Ingress meta field kinds
    typedef enum logic [`AWP_META_W-1:0] {
        META_IGN0  = 2'd0,
        META_CFG   = `AWP_META_CFG,
        META_PIXEL = `AWP_META_PIXEL,
        META_IGN3  = 2'd3
    } meta_kind_e;

    // Named signed lanes so element selects stay signed
    typedef logic signed [`AWP_WEIGHT_W-1:0] weight_t;
    typedef logic signed [`AWP_PIXEL_W-1:0]  pixel_t;

    // Lane i at the low end, one per quad
    typedef weight_t [`AWP_NUM_QUADS-1:0] weight_vec_t;
    typedef pixel_t  [`AWP_NUM_QUADS-1:0] pixel_vec_t;

    // Configuration layout of the payload
    typedef struct packed {
        logic [`AWP_PYLD_W-`AWP_CREDIT_W-(`AWP_NUM_QUADS*`AWP_WEIGHT_W)-1:0] rsvd;
        // Result high watermark, bits 36 to 32
        logic [`AWP_CREDIT_W-1:0] wmark;
        weight_vec_t              weights;
    } cfg_view_t;

    // Same 64 bits, read by meta kind
    typedef union packed {
        cfg_view_t  cfg;
        pixel_vec_t pix;
    } trans_pyld_u;

endpackage

`default_nettype wire

// ==== decode/trans_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "awp_defines.svh"

module trans_decode
    import awp_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_vld,
    output logic                              in_rdy,
    input  logic [`AWP_META_W+`AWP_PYLD_W-1:0] in_data,
    input  logic                              pop,
    output logic                              issue_vld,
    output pixel_vec_t                        issue_pixels,
    output weight_vec_t                       issue_weights
);

    localparam logic [`AWP_CREDIT_W-1:0] WMARK_RST = `AWP_WMARK_DEFAULT;
    localparam logic [`AWP_CREDIT_W-1:0] WMARK_MAX = `AWP_FIFO_DEPTH;

    meta_kind_e                meta;
    trans_pyld_u               pyld;
    logic                      accept;
    logic                      is_cfg;
    logic                      is_pixel;
    logic                      take_pixel;
    logic [`AWP_CREDIT_W-1:0]  wmark_dec;
    logic [`AWP_CREDIT_W-1:0]  wmark_q;
    logic [`AWP_CREDIT_W-1:0]  credits;
    weight_vec_t               weights_q;

    //////////////////////////////////////////////////
    // Ingress word split
    //////////////////////////////////////////////////

    // Meta rides in the top two bits
    assign meta   = meta_kind_e'(in_data[`AWP_META_W+`AWP_PYLD_W-1 -: `AWP_META_W]);
    assign pyld   = in_data[`AWP_PYLD_W-1:0];
    assign accept = in_vld && in_rdy;

    always_comb begin
        is_cfg   = 1'b0;
        is_pixel = 1'b0;
        case (meta)
            META_CFG:   is_cfg = 1'b1;
            META_PIXEL: is_pixel = 1'b1;
            // Other kinds are taken and dropped
            default: ;
        endcase
    end

    assign take_pixel = accept && is_pixel;

    // Zero or past FIFO depth means full depth
    assign wmark_dec = (pyld.cfg.wmark == '0 || pyld.cfg.wmark > WMARK_MAX) ?
                       WMARK_MAX : pyld.cfg.wmark;

    //////////////////////////////////////////////////
    // Configuration registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            weights_q <= '0;
            wmark_q   <= WMARK_RST;
        end else if (accept && is_cfg) begin
            weights_q <= pyld.cfg.weights;
            wmark_q   <= wmark_dec;
        end
    end

    // Pixel issue, weights sampled at accept
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_vld <= 1'b0;
        end else begin
            issue_vld <= take_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (take_pixel) begin
            issue_pixels  <= pyld.pix;
            issue_weights <= weights_q;
        end
    end

    //////////////////////////////////////////////////
    // Credits, in flight plus queued results
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else if (take_pixel && !pop) begin
            credits <= credits + 1'b1;
        end else if (!take_pixel && pop) begin
            credits <= credits - 1'b1;
        end
    end

    // Hold off ingress at the watermark
    assign in_rdy = (credits < wmark_q);

    // Egress pops only results this counter has seen
    a_credit_underflow: assert property (
        @(posedge clk) disable iff (rst) pop |-> credits != '0
    ) else $error("credit counter underflow");

    a_credit_range: assert property (
        @(posedge clk) disable iff (rst) take_pixel |=> credits <= WMARK_MAX
    ) else $error("credit counter above FIFO depth");

endmodule

`default_nettype wire

// ==== execute/quad_chain.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "awp_defines.svh"

module quad_chain
    import awp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_vld,
    input  pixel_vec_t              issue_pixels,
    input  weight_vec_t             issue_weights,
    output logic                    mac_vld,
    output logic [`AWP_PIXEL_W-1:0] mac_sum
);

    localparam int NQ = `AWP_NUM_QUADS;

    // Per stage valid and cascade sum
    logic                           vld_q [NQ];
    logic signed [`AWP_PIXEL_W-1:0] sum_q [NQ];
    // Skew copies, last stage needs none
    pixel_vec_t                     pix_q [NQ-1];
    weight_vec_t                    wgt_q [NQ-1];

    genvar gi;
    generate
        for (gi = 0; gi < NQ; gi++) begin : g_quad
            if (gi == 0) begin : g_head
                always_ff @(posedge clk) begin
                    if (rst) begin
                        vld_q[gi] <= 1'b0;
                    end else begin
                        vld_q[gi] <= issue_vld;
                    end
                end

                // Head quad starts the cascade from zero
                always_ff @(posedge clk) begin
                    sum_q[gi] <= $signed(issue_pixels[gi]) * $signed(issue_weights[gi]);
                    pix_q[gi] <= issue_pixels;
                    wgt_q[gi] <= issue_weights;
                end
            end else begin : g_body
                always_ff @(posedge clk) begin
                    if (rst) begin
                        vld_q[gi] <= 1'b0;
                    end else begin
                        vld_q[gi] <= vld_q[gi-1];
                    end
                end

                // Lane gi arrives skewed by gi cycles, aligned with upstream sum
                always_ff @(posedge clk) begin
                    sum_q[gi] <= sum_q[gi-1] +
                                 $signed(pix_q[gi-1][gi]) * $signed(wgt_q[gi-1][gi]);
                end

                if (gi < NQ-1) begin : g_skew
                    always_ff @(posedge clk) begin
                        pix_q[gi] <= pix_q[gi-1];
                        wgt_q[gi] <= wgt_q[gi-1];
                    end
                end
            end
        end
    endgenerate

    // Tail of the cascade, wraps modulo 2^16
    assign mac_vld = vld_q[NQ-1];
    assign mac_sum = sum_q[NQ-1];

    // Fixed latency, one item per stage
    a_latency_fwd: assert property (
        @(posedge clk) disable iff (rst) issue_vld |-> ##NQ mac_vld
    ) else $error("result missing after chain latency");

    a_latency_back: assert property (
        @(posedge clk) disable iff (rst) mac_vld |-> $past(issue_vld, NQ)
    ) else $error("result without matching issue");

endmodule

`default_nettype wire

// ==== result/convmap_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "awp_defines.svh"

module convmap_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mac_vld,
    input  logic [`AWP_PIXEL_W-1:0] mac_sum,
    output logic                    out_vld,
    input  logic                    out_rdy,
    output logic [`AWP_PIXEL_W-1:0] out_data,
    output logic                    pop
);

    localparam int DEPTH = `AWP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`AWP_PIXEL_W-1:0]  mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [`AWP_CREDIT_W-1:0] count;

    //////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////

    // Every chain result is written, no stall path
    always_ff @(posedge clk) begin
        if (mac_vld) begin
            mem[wr_ptr] <= mac_sum;
        end
    end

    // Pointers wrap on the power of two depth
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (mac_vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({mac_vld, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Egress side, head word shown directly
    //////////////////////////////////////////////////

    assign out_vld  = (count != '0);
    assign out_data = mem[rd_ptr];
    // Egress transfer, also returns a credit
    assign pop      = out_vld && out_rdy;

    // Upstream credits must keep the chain off a full buffer
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) mac_vld |-> count < DEPTH
    ) else $error("result written into full FIFO");

endmodule

`default_nettype wire

// ==== src/awp_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "awp_defines.svh"

module awp_top
    import awp_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    // Ingress transaction words
    input  logic                               in_vld,
    output logic                               in_rdy,
    input  logic [`AWP_META_W+`AWP_PYLD_W-1:0] in_data,
    // Egress dot products
    output logic                               out_vld,
    input  logic                               out_rdy,
    output logic [`AWP_PIXEL_W-1:0]            out_data
);

    // Decode to chain
    logic                    issue_vld;
    pixel_vec_t              issue_pixels;
    weight_vec_t             issue_weights;
    // Chain to result FIFO
    logic                    mac_vld;
    logic [`AWP_PIXEL_W-1:0] mac_sum;
    // Credit return
    logic                    pop;

    trans_decode u_decode (
        .clk           (clk),
        .rst           (rst),
        .in_vld        (in_vld),
        .in_rdy        (in_rdy),
        .in_data       (in_data),
        .pop           (pop),
        .issue_vld     (issue_vld),
        .issue_pixels  (issue_pixels),
        .issue_weights (issue_weights)
    );

    quad_chain u_chain (
        .clk           (clk),
        .rst           (rst),
        .issue_vld     (issue_vld),
        .issue_pixels  (issue_pixels),
        .issue_weights (issue_weights),
        .mac_vld       (mac_vld),
        .mac_sum       (mac_sum)
    );

    convmap_fifo u_fifo (
        .clk      (clk),
        .rst      (rst),
        .mac_vld  (mac_vld),
        .mac_sum  (mac_sum),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data),
        .pop      (pop)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_awp_tasks.svh ====
`ifndef TB_AWP_TASKS_SVH
`define TB_AWP_TASKS_SVH

//////////////////////////////////////////////////
// Ingress word builders
//////////////////////////////////////////////////

// Weights low, watermark in bits 36 to 32
function automatic logic [WORD_W-1:0] cfg_word(input logic [31:0] w, input logic [4:0] wmark);
    return {`AWP_META_CFG, 27'd0, wmark, w};
endfunction

function automatic logic [WORD_W-1:0] pixel_word(input logic [63:0] pix);
    return {`AWP_META_PIXEL, pix};
endfunction

//////////////////////////////////////////////////
// Drivers, all on the falling edge
//////////////////////////////////////////////////

// Hold the word until ready, ready is stable between edges
task automatic send_word(input logic [WORD_W-1:0] word);
    int waited;
    waited = 0;
    @(negedge clk);
    in_vld  = 1'b1;
    in_data = word;
    while (!in_rdy && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (!in_rdy) begin
        raise_timeout("ingress word was never accepted");
    end else begin
        // Next rising edge takes it
        model_accept(word);
        accept_cycle = cycle + 1;
        @(negedge clk);
    end
    in_vld = 1'b0;
endtask

task automatic set_out_rdy(input logic value);
    @(negedge clk);
    rand_rdy = 1'b0;
    out_rdy  = value;
endtask

// Result seen at the next rising edge counts as its arrival
task automatic wait_out_vld(output int latency);
    int waited;
    waited  = 0;
    latency = 0;
    while (!out_vld && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (!out_vld) begin
        raise_timeout("egress valid never rose");
    end else begin
        latency = cycle + 1 - accept_cycle;
    end
endtask

// Needs egress ready held high
task automatic drain_results();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || out_vld) && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (exp_q.size() != 0 || out_vld) begin
        raise_timeout("results did not drain from the result FIFO");
    end
endtask

`endif

// ==== testbench/tb_awp.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "awp_defines.svh"

module tb_awp;

    localparam int WAIT_LIMIT   = 200;
    localparam int GLOBAL_LIMIT = 20000;
    localparam int WORD_W       = `AWP_META_W + `AWP_PYLD_W;
    // Weight sets with lane 0 in the low byte
    localparam logic [31:0] W_A = 32'h05FE7F81;
    localparam logic [31:0] W_B = 32'h80017FF3;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    in_vld;
    logic                    in_rdy;
    logic [WORD_W-1:0]       in_data;
    logic                    out_vld;
    logic                    out_rdy;
    logic [`AWP_PIXEL_W-1:0] out_data;

    // Reference model
    logic [15:0] exp_q[$];
    logic [15:0] exp_head;
    int          exp_count;
    logic [31:0] model_weights;

    int          cycle;
    int          accept_cycle;
    int          err_count;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;
    logic        timed_out;
    logic        rand_rdy;

    awp_top dut (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (in_vld),
        .in_rdy   (in_rdy),
        .in_data  (in_data),
        .out_vld  (out_vld),
        .out_rdy  (out_rdy),
        .out_data (out_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////
    // Model and bookkeeping
    //////////////////////////////////////////////////

    // Wrapped sum of pixel times weight over all lanes
    function automatic logic [15:0] expected_dot(input logic [63:0] pix, input logic [31:0] w);
        int acc;
        int p;
        int q;
        acc = 0;
        for (int i = 0; i < `AWP_NUM_QUADS; i++) begin
            p = {{16{pix[16*i+15]}}, pix[16*i +: 16]};
            q = {{24{w[8*i+7]}}, w[8*i +: 8]};
            acc += p * q;
        end
        return acc[15:0];
    endfunction

    task automatic refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : 16'h0000;
    endtask

    // Other meta kinds leave the model alone
    task automatic model_accept(input logic [WORD_W-1:0] word);
        case (word[WORD_W-1 -: 2])
            `AWP_META_CFG: model_weights = word[31:0];
            `AWP_META_PIXEL: begin
                exp_q.push_back(expected_dot(word[63:0], model_weights));
                refresh_head();
            end
            default: ;
        endcase
    endtask

    task automatic note_error(input string msg);
        err_count++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic raise_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        timed_out = 1'b1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_count == test_err_base) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d error(s)", tests_run, name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    task automatic finish_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (!timed_out && err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    `include "tb_awp_tasks.svh"

    //////////////////////////////////////////////////
    // Egress checks against the model
    //////////////////////////////////////////////////

    // Pop after the transfer edge
    always @(posedge clk) begin
        if (!rst && out_vld && out_rdy && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_egress_expected: assert property (
        @(posedge clk) disable iff (rst) (out_vld && out_rdy) |-> exp_count != 0
    ) else note_error("egress word with no expected result");

    a_egress_value: assert property (
        @(posedge clk) disable iff (rst)
        (out_vld && out_rdy && exp_count != 0) |-> out_data == exp_head
    ) else note_error($sformatf("egress data %h, expected %h",
                                $sampled(out_data), $sampled(exp_head)));

    // Held word must stay put
    a_egress_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_data))
    ) else note_error("egress word dropped or changed under back-pressure");

    // Random egress back-pressure
    always @(negedge clk) begin
        if (rand_rdy) begin
            out_rdy = ($urandom % 4) != 0;
        end
    end

    initial begin : watchdog
        int n;
        n = 0;
        while (!timed_out && n < GLOBAL_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!timed_out) begin
            $display("Run did not finish within %0d cycles", GLOBAL_LIMIT);
            timed_out = 1'b1;
        end
        finish_run();
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int          lat;
        logic [31:0] rnd;
        void'($urandom(34));
        rst           = 1'b1;
        in_vld        = 1'b0;
        in_data       = '0;
        out_rdy       = 1'b0;
        rand_rdy      = 1'b0;
        timed_out     = 1'b0;
        cycle         = 0;
        accept_cycle  = 0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        test_err_base = 0;
        model_weights = '0;
        refresh_head();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state with zero weights
        assert (!out_vld && in_rdy) else note_error("out_vld or in_rdy wrong after reset");
        set_out_rdy(1'b1);
        send_word(pixel_word(64'h0005_FFF0_0123_7FFF));
        send_word(pixel_word(64'h8000_1234_FFFF_0001));
        drain_results();
        end_test("reset and zero weights");

        send_word(cfg_word(W_A, 5'd0));
        send_word(pixel_word(64'h0003_FFFE_0102_7FFF));
        wait_out_vld(lat);
        assert (lat == 6) else note_error($sformatf("first result after %0d cycles", lat));
        send_word(pixel_word(64'h7FFF_7FFF_7FFF_7FFF));
        send_word(pixel_word(64'h8000_8000_8000_8000));
        send_word(pixel_word(64'h1111_EEEE_2222_DDDD));
        drain_results();
        end_test("dot products and latency");

        // Old weights stay with words already taken
        send_word(pixel_word(64'h0010_0020_0030_0040));
        send_word(cfg_word(W_B, 5'd0));
        send_word(pixel_word(64'h0010_0020_0030_0040));
        send_word(cfg_word(W_A, 5'd0));
        send_word(pixel_word(64'hFFF0_0200_ABCD_0007));
        drain_results();
        end_test("reconfigure between words");

        set_out_rdy(1'b0);
        send_word(cfg_word(W_B, 5'd3));
        send_word(pixel_word(64'h0001_0002_0003_0004));
        send_word(pixel_word(64'h0005_0006_0007_0008));
        send_word(pixel_word(64'h0009_000A_000B_000C));
        assert (!in_rdy) else note_error("in_rdy high at watermark");
        repeat (10) @(negedge clk);
        assert (!in_rdy && out_vld) else note_error("back-pressure state lost");
        set_out_rdy(1'b1);
        send_word(pixel_word(64'h000D_000E_000F_0010));
        send_word(pixel_word(64'hF00D_BEEF_CAFE_0011));
        drain_results();
        send_word(cfg_word(W_B, 5'd16));
        end_test("watermark back-pressure");

        // Ignored kinds carry weight-like payloads
        send_word(cfg_word(W_A, 5'd0));
        send_word({2'd0, 64'hFFFF_FFFF_FFFF_FFFF});
        send_word({2'd3, 64'h0000_0000_1234_5678});
        repeat (12) begin
            @(negedge clk);
            assert (!out_vld) else note_error("egress word from ignored kind");
        end
        send_word(pixel_word(64'h0100_0200_0300_0400));
        drain_results();
        end_test("ignored meta kinds");

        @(negedge clk);
        rand_rdy = 1'b1;
        for (int k = 0; k < 80; k++) begin
            rnd = $urandom;
            if (rnd % 6 == 0) begin
                send_word(cfg_word($urandom, rnd[12:8]));
            end else begin
                send_word(pixel_word({$urandom, $urandom}));
            end
        end
        set_out_rdy(1'b1);
        drain_results();
        assert (exp_q.size() == 0) else note_error("model queue not empty at end");
        end_test("random stream");

        finish_run();
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
+incdir+testbench
common/awp_pkg.sv
decode/trans_decode.sv
execute/quad_chain.sv
result/convmap_fifo.sv
src/awp_top.sv
testbench/tb_awp.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_awp
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
